/* ctrl_types_pkg.sv */
package ctrl_types_pkg;

    // architectural register file
    localparam int unsigned NUM_LREG = 32;
    localparam int unsigned LREG_W   = 5;

    // physical register numbers, at most 64 registers
    localparam int unsigned PREG_W   = 6;

    localparam int unsigned PC_W     = 64;

    typedef logic [LREG_W-1:0] lreg_t;
    typedef logic [PREG_W-1:0] preg_t;
    typedef logic [PC_W-1:0]   pc_t;

endpackage

/* rob_pkg.sv */
package rob_pkg;

    localparam int unsigned ROB_IDX_W = 4;
    localparam int unsigned ROB_DEPTH = 1 << ROB_IDX_W;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // completion state of one entry
    typedef enum logic {
        ROB_WAIT,
        ROB_DONE
    } rob_state_t;

endpackage

/* rename_table.sv */
module rename_table import ctrl_types_pkg::*; #(
    parameter int unsigned NUM_PREG = 40
) (
    input  logic  clock,
    input  logic  reset_n,
    input  lreg_t lrs1,
    input  lreg_t lrs2,
    input  lreg_t lrd,
    input  logic  alloc_valid,
    input  preg_t alloc_prd,
    input  logic  commit_valid,
    input  logic  commit_need_to_wb,
    input  lreg_t commit_lrd,
    input  preg_t commit_prd,
    output preg_t prs1,
    output preg_t prs2,
    output preg_t old_prd
);

    // entries only need to reach NUM_PREG-1
    localparam int unsigned MAP_W = $clog2(NUM_PREG);

    typedef logic [MAP_W-1:0] map_ent_t;

    map_ent_t spec_map [NUM_LREG];
    map_ent_t arch_map [NUM_LREG];

    // combinational lookups, results reflect the last acceptance edge
    assign prs1    = preg_t'(spec_map[lrs1]);
    assign prs2    = preg_t'(spec_map[lrs2]);
    assign old_prd = preg_t'(spec_map[lrd]);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_LREG; i++) begin
                spec_map[i] <= map_ent_t'(i);
            end
        end else if (alloc_valid) begin
            spec_map[lrd] <= map_ent_t'(alloc_prd);
        end
    end

    // committed state, source for a later flush restore
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < NUM_LREG; i++) begin
                arch_map[i] <= map_ent_t'(i);
            end
        end else if (commit_valid && commit_need_to_wb) begin
            arch_map[commit_lrd] <= map_ent_t'(commit_prd);
        end
    end

endmodule

/* free_list.sv */
module free_list import ctrl_types_pkg::*; #(
    parameter int unsigned NUM_PREG = 40
) (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  pop,
    input  logic  push,
    input  preg_t push_prd,
    output preg_t head_prd,
    output logic  empty
);

    localparam int unsigned FL_SIZE = NUM_PREG - NUM_LREG;
    localparam int unsigned PTR_W   = (FL_SIZE > 1) ? $clog2(FL_SIZE) : 1;
    localparam int unsigned CNT_W   = $clog2(FL_SIZE + 1);

    typedef logic [PTR_W-1:0] ptr_t;

    localparam ptr_t PTR_LAST = ptr_t'(FL_SIZE - 1);

    preg_t             slots [FL_SIZE];
    ptr_t              head_ptr;
    ptr_t              tail_ptr;
    logic [CNT_W-1:0]  count;

    assign head_prd = slots[head_ptr];
    assign empty    = (count == '0);

    function automatic ptr_t ptr_next(input ptr_t ptr);
        return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
    endfunction

    // queue starts out holding 32..NUM_PREG-1 in ascending order
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < FL_SIZE; i++) begin
                slots[i] <= preg_t'(NUM_LREG + i);
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= CNT_W'(FL_SIZE);
        end else begin
            if (pop) begin
                head_ptr <= ptr_next(head_ptr);
            end
            // released registers go in behind the remaining free ones
            if (push) begin
                slots[tail_ptr] <= push_prd;
                tail_ptr        <= ptr_next(tail_ptr);
            end
            if (pop && !push) begin
                count <= count - 1'b1;
            end else if (push && !pop) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

/* busy_table.sv */
module busy_table import ctrl_types_pkg::*; #(
    parameter int unsigned NUM_PREG = 40
) (
    input  logic  clock,
    input  logic  reset_n,
    input  preg_t rd_addr0,
    input  preg_t rd_addr1,
    input  logic  set_en,
    input  preg_t set_addr,
    input  logic  clear_en,
    input  preg_t clear_addr,
    output logic  busy0,
    output logic  busy1
);

    logic [NUM_PREG-1:0] busy;

    assign busy0 = busy[rd_addr0];
    assign busy1 = busy[rd_addr1];

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (clear_en) begin
                busy[clear_addr] <= 1'b0;
            end
            // a fresh allocation never matches a pending write-back
            if (set_en) begin
                busy[set_addr] <= 1'b1;
            end
        end
    end

endmodule

/* reorder_buffer.sv */
module reorder_buffer import ctrl_types_pkg::*, rob_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     enq_valid,
    input  pc_t      enq_pc,
    input  lreg_t    enq_lrd,
    input  preg_t    enq_prd,
    input  preg_t    enq_old_prd,
    input  logic     enq_need_to_wb,
    input  logic     wb_valid,
    input  rob_idx_t wb_robidx,
    output logic     full,
    output rob_idx_t enq_idx,
    output logic     enq_flag,
    output logic     commit_valid,
    output pc_t      commit_pc,
    output lreg_t    commit_lrd,
    output preg_t    commit_prd,
    output preg_t    commit_old_prd,
    output logic     commit_need_to_wb
);

    pc_t        ent_pc         [ROB_DEPTH];
    lreg_t      ent_lrd        [ROB_DEPTH];
    preg_t      ent_prd        [ROB_DEPTH];
    preg_t      ent_old_prd    [ROB_DEPTH];
    logic       ent_need_to_wb [ROB_DEPTH];
    rob_state_t ent_state      [ROB_DEPTH];

    rob_idx_t head_idx;
    logic     head_flag;
    rob_idx_t tail_idx;
    logic     tail_flag;
    logic     empty;

    // same index, flag tells empty from full
    assign empty = (head_idx == tail_idx) && (head_flag == tail_flag);
    assign full  = (head_idx == tail_idx) && (head_flag != tail_flag);

    assign enq_idx  = tail_idx;
    assign enq_flag = tail_flag;

    assign commit_valid      = !empty && (ent_state[head_idx] == ROB_DONE);
    assign commit_pc         = ent_pc[head_idx];
    assign commit_lrd        = ent_lrd[head_idx];
    assign commit_prd        = ent_prd[head_idx];
    assign commit_old_prd    = ent_old_prd[head_idx];
    assign commit_need_to_wb = ent_need_to_wb[head_idx];

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            ent_pc[tail_idx]         <= enq_pc;
            ent_lrd[tail_idx]        <= enq_lrd;
            // non-writing entries keep their old mapping as prd
            ent_prd[tail_idx]        <= enq_need_to_wb ? enq_prd : enq_old_prd;
            ent_old_prd[tail_idx]    <= enq_old_prd;
            ent_need_to_wb[tail_idx] <= enq_need_to_wb;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                ent_state[i] <= ROB_WAIT;
            end
        end else begin
            if (enq_valid) begin
                ent_state[tail_idx] <= ROB_WAIT;
            end
            if (wb_valid) begin
                ent_state[wb_robidx] <= ROB_DONE;
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head_idx  <= '0;
            head_flag <= 1'b0;
            tail_idx  <= '0;
            tail_flag <= 1'b0;
        end else begin
            if (enq_valid) begin
                {tail_flag, tail_idx} <= {tail_flag, tail_idx} + 1'b1;
            end
            // one commit per cycle
            if (commit_valid) begin
                {head_flag, head_idx} <= {head_flag, head_idx} + 1'b1;
            end
        end
    end

endmodule

/* rename_stage.sv */
module rename_stage import ctrl_types_pkg::*, rob_pkg::*; (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     in_valid,
    input  lreg_t    in_lrs1,
    input  lreg_t    in_lrs2,
    input  lreg_t    in_lrd,
    input  logic     in_need_to_wb,
    input  pc_t      in_pc,
    input  preg_t    prs1,
    input  preg_t    prs2,
    input  preg_t    old_prd,
    input  preg_t    fl_head,
    input  logic     fl_empty,
    input  logic     rob_full,
    input  rob_idx_t enq_idx,
    input  logic     enq_flag,
    input  logic     issue_ready,
    output logic     in_ready,
    output logic     accept,
    output logic     alloc,
    output logic     issue_valid,
    output pc_t      issue_pc,
    output lreg_t    issue_lrd,
    output preg_t    issue_prs1,
    output preg_t    issue_prs2,
    output preg_t    issue_prd,
    output preg_t    issue_old_prd,
    output logic     issue_need_to_wb,
    output rob_idx_t issue_robidx,
    output logic     issue_robidx_flag
);

    logic  out_free;
    preg_t src1;
    preg_t src2;
    preg_t new_prd;

    // output register empty or leaving this cycle
    assign out_free = !issue_valid || issue_ready;

    assign in_ready = out_free && !rob_full && (!fl_empty || !in_need_to_wb);
    assign accept   = in_valid && in_ready;
    assign alloc    = accept && in_need_to_wb;

    // x0 always reads p0
    assign src1    = (in_lrs1 == '0) ? '0 : prs1;
    assign src2    = (in_lrs2 == '0) ? '0 : prs2;
    assign new_prd = in_need_to_wb ? fl_head : old_prd;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= 1'b0;
        end else if (accept) begin
            issue_valid <= 1'b1;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    // held as long as nothing new is accepted
    always_ff @(posedge clock) begin
        if (accept) begin
            issue_pc          <= in_pc;
            issue_lrd         <= in_lrd;
            issue_prs1        <= src1;
            issue_prs2        <= src2;
            issue_prd         <= new_prd;
            issue_old_prd     <= old_prd;
            issue_need_to_wb  <= in_need_to_wb;
            issue_robidx      <= enq_idx;
            issue_robidx_flag <= enq_flag;
        end
    end

endmodule

/* ctrl_block.sv */
module ctrl_block import ctrl_types_pkg::*, rob_pkg::*; #(
    parameter int unsigned NUM_PREG = 40
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     in_valid,
    input  lreg_t    in_lrs1,
    input  lreg_t    in_lrs2,
    input  lreg_t    in_lrd,
    input  logic     in_need_to_wb,
    input  pc_t      in_pc,
    output logic     in_ready,
    input  logic     issue_ready,
    output logic     issue_valid,
    output pc_t      issue_pc,
    output lreg_t    issue_lrd,
    output preg_t    issue_prs1,
    output preg_t    issue_prs2,
    output preg_t    issue_prd,
    output preg_t    issue_old_prd,
    output logic     issue_need_to_wb,
    output rob_idx_t issue_robidx,
    output logic     issue_robidx_flag,
    output logic     issue_src1_busy,
    output logic     issue_src2_busy,
    input  logic     wb_valid,
    input  rob_idx_t wb_robidx,
    input  logic     wb_need_to_wb,
    input  preg_t    wb_prd,
    output logic     commit_valid,
    output pc_t      commit_pc,
    output lreg_t    commit_lrd,
    output preg_t    commit_prd,
    output preg_t    commit_old_prd,
    output logic     commit_need_to_wb
);

    logic     enq_valid;
    logic     alloc_valid;
    preg_t    prs1;
    preg_t    prs2;
    preg_t    old_prd;
    preg_t    fl_head;
    logic     fl_empty;
    logic     rob_full;
    rob_idx_t enq_idx;
    logic     enq_flag;
    logic     wb_clear;
    logic     fl_push;

    // only register-writing results touch busy bits and the free list
    assign wb_clear = wb_valid && wb_need_to_wb;
    assign fl_push  = commit_valid && commit_need_to_wb;

    rename_stage u_rename_stage (
        .clock(clock), .reset_n(reset_n),
        .in_valid(in_valid), .in_lrs1(in_lrs1), .in_lrs2(in_lrs2), .in_lrd(in_lrd),
        .in_need_to_wb(in_need_to_wb), .in_pc(in_pc),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd),
        .fl_head(fl_head), .fl_empty(fl_empty), .rob_full(rob_full),
        .enq_idx(enq_idx), .enq_flag(enq_flag), .issue_ready(issue_ready),
        .in_ready(in_ready), .accept(enq_valid), .alloc(alloc_valid),
        .issue_valid(issue_valid), .issue_pc(issue_pc), .issue_lrd(issue_lrd),
        .issue_prs1(issue_prs1), .issue_prs2(issue_prs2), .issue_prd(issue_prd),
        .issue_old_prd(issue_old_prd), .issue_need_to_wb(issue_need_to_wb),
        .issue_robidx(issue_robidx), .issue_robidx_flag(issue_robidx_flag)
    );

    rename_table #(.NUM_PREG(NUM_PREG)) u_rename_table (
        .clock(clock), .reset_n(reset_n),
        .lrs1(in_lrs1), .lrs2(in_lrs2), .lrd(in_lrd),
        .alloc_valid(alloc_valid), .alloc_prd(fl_head),
        .commit_valid(commit_valid), .commit_need_to_wb(commit_need_to_wb),
        .commit_lrd(commit_lrd), .commit_prd(commit_prd),
        .prs1(prs1), .prs2(prs2), .old_prd(old_prd)
    );

    free_list #(.NUM_PREG(NUM_PREG)) u_free_list (
        .clock(clock), .reset_n(reset_n),
        .pop(alloc_valid), .push(fl_push), .push_prd(commit_old_prd),
        .head_prd(fl_head), .empty(fl_empty)
    );

    busy_table #(.NUM_PREG(NUM_PREG)) u_busy_table (
        .clock(clock), .reset_n(reset_n),
        .rd_addr0(issue_prs1), .rd_addr1(issue_prs2),
        .set_en(alloc_valid), .set_addr(fl_head),
        .clear_en(wb_clear), .clear_addr(wb_prd),
        .busy0(issue_src1_busy), .busy1(issue_src2_busy)
    );

    reorder_buffer u_reorder_buffer (
        .clock(clock), .reset_n(reset_n),
        .enq_valid(enq_valid), .enq_pc(in_pc), .enq_lrd(in_lrd),
        .enq_prd(fl_head), .enq_old_prd(old_prd), .enq_need_to_wb(in_need_to_wb),
        .wb_valid(wb_valid), .wb_robidx(wb_robidx),
        .full(rob_full), .enq_idx(enq_idx), .enq_flag(enq_flag),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_lrd(commit_lrd),
        .commit_prd(commit_prd), .commit_old_prd(commit_old_prd),
        .commit_need_to_wb(commit_need_to_wb)
    );

endmodule

/* tb_ctrl_block.sv */
module tb_ctrl_block import ctrl_types_pkg::*, rob_pkg::*;;

    localparam int unsigned NUM_PREG    = 40;
    // watchdog limit scales with the instructions sent over all tests
    localparam int          NUM_INSTR   = 60;
    localparam int          ACCEPT_WAIT = 40;
    localparam int          DRAIN_WAIT  = 60;

    logic     clock;
    logic     reset_n;
    logic     in_valid;
    lreg_t    in_lrs1;
    lreg_t    in_lrs2;
    lreg_t    in_lrd;
    logic     in_need_to_wb;
    pc_t      in_pc;
    logic     in_ready;
    logic     issue_ready;
    logic     issue_valid;
    pc_t      issue_pc;
    lreg_t    issue_lrd;
    preg_t    issue_prs1;
    preg_t    issue_prs2;
    preg_t    issue_prd;
    preg_t    issue_old_prd;
    logic     issue_need_to_wb;
    rob_idx_t issue_robidx;
    logic     issue_robidx_flag;
    logic     issue_src1_busy;
    logic     issue_src2_busy;
    logic     wb_valid;
    rob_idx_t wb_robidx;
    logic     wb_need_to_wb;
    preg_t    wb_prd;
    logic     commit_valid;
    pc_t      commit_pc;
    lreg_t    commit_lrd;
    preg_t    commit_prd;
    preg_t    commit_old_prd;
    logic     commit_need_to_wb;

    // reference model of the maps, free queue, busy bits and ROB
    preg_t       m_map [NUM_LREG];
    preg_t       m_free [$];
    logic [63:0] m_busy;
    pc_t         m_pc   [ROB_DEPTH];
    lreg_t       m_lrd  [ROB_DEPTH];
    preg_t       m_prd  [ROB_DEPTH];
    preg_t       m_old  [ROB_DEPTH];
    logic        m_need [ROB_DEPTH];
    logic        m_done [ROB_DEPTH];
    int          m_head;
    int          m_tail;

    // expected contents of the issue output register
    logic     e_valid;
    pc_t      e_pc;
    lreg_t    e_lrd;
    preg_t    e_prs1;
    preg_t    e_prs2;
    preg_t    e_prd;
    preg_t    e_old;
    logic     e_need;
    rob_idx_t e_idx;
    logic     e_flag;

    int          mismatch_count = 0;
    int          fail_count     = 0;
    int          accept_count   = 0;
    rob_idx_t    last_idx;
    pc_t         next_pc        = 64'h8000_0000;
    logic [31:0] rng_state      = 32'h0aaa_f4af;

    ctrl_block #(.NUM_PREG(NUM_PREG)) u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    initial begin
        repeat (400 * NUM_INSTR) @(posedge clock);
        $display("watchdog expired after %0d cycles, the run did not finish", 400 * NUM_INSTR);
        $display("TEST FAIL");
        $finish;
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // any register but x0
    function automatic lreg_t pick_lreg();
        logic [31:0] r;
        r = next_random();
        return lreg_t'(1 + (r >> 16) % 31);
    endfunction

    task automatic check_preg(input string name, input preg_t got, input preg_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, input rob_idx_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_lreg(input string name, input lreg_t got, input lreg_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one clock cycle from falling edge to falling edge
    task automatic run_cycle();
        int   h;
        int   t;
        logic exp_commit;
        logic exp_ready;
        #2;
        check_bit("issue_valid", issue_valid, e_valid);
        if (e_valid) begin
            check_pc("issue_pc", issue_pc, e_pc);
            check_lreg("issue_lrd", issue_lrd, e_lrd);
            check_preg("issue_prs1", issue_prs1, e_prs1);
            check_preg("issue_prs2", issue_prs2, e_prs2);
            check_preg("issue_prd", issue_prd, e_prd);
            check_preg("issue_old_prd", issue_old_prd, e_old);
            check_bit("issue_need_to_wb", issue_need_to_wb, e_need);
            check_idx("issue_robidx", issue_robidx, e_idx);
            check_bit("issue_robidx_flag", issue_robidx_flag, e_flag);
            check_bit("issue_src1_busy", issue_src1_busy, m_busy[e_prs1]);
            check_bit("issue_src2_busy", issue_src2_busy, m_busy[e_prs2]);
        end
        h = m_head % ROB_DEPTH;
        exp_commit = (m_tail != m_head) && m_done[h];
        check_bit("commit_valid", commit_valid, exp_commit);
        if (exp_commit && commit_valid) begin
            check_pc("commit_pc", commit_pc, m_pc[h]);
            check_lreg("commit_lrd", commit_lrd, m_lrd[h]);
            check_preg("commit_prd", commit_prd, m_prd[h]);
            check_preg("commit_old_prd", commit_old_prd, m_old[h]);
            check_bit("commit_need_to_wb", commit_need_to_wb, m_need[h]);
        end
        exp_ready = (!e_valid || issue_ready) && ((m_tail - m_head) < int'(ROB_DEPTH))
                    && (m_free.size() != 0 || !in_need_to_wb);
        check_bit("in_ready", in_ready, exp_ready);

        // model state after the coming rising edge
        if (e_valid && issue_ready) begin
            e_valid = 1'b0;
        end
        if (wb_valid && wb_need_to_wb) begin
            m_busy[wb_prd] = 1'b0;
        end
        if (in_valid && in_ready) begin
            t       = m_tail % ROB_DEPTH;
            e_valid = 1'b1;
            e_pc    = in_pc;
            e_lrd   = in_lrd;
            e_prs1  = m_map[in_lrs1];
            e_prs2  = m_map[in_lrs2];
            e_old   = m_map[in_lrd];
            e_need  = in_need_to_wb;
            e_idx   = rob_idx_t'(t);
            e_flag  = logic'((m_tail / ROB_DEPTH) % 2);
            e_prd   = e_old;
            if (in_need_to_wb) begin
                e_prd          = m_free.pop_front();
                m_map[in_lrd]  = e_prd;
                m_busy[e_prd]  = 1'b1;
            end
            m_pc[t]   = in_pc;
            m_lrd[t]  = in_lrd;
            m_prd[t]  = e_prd;
            m_old[t]  = e_old;
            m_need[t] = in_need_to_wb;
            m_done[t] = 1'b0;
            m_tail++;
            last_idx  = e_idx;
            accept_count++;
        end
        if (exp_commit) begin
            if (m_need[h]) begin
                m_free.push_back(m_old[h]);
            end
            m_head++;
        end
        if (wb_valid) begin
            m_done[wb_robidx] = 1'b1;
        end
        @(negedge clock);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) run_cycle();
    endtask

    task automatic drive_instr(input lreg_t lrs1, input lreg_t lrs2, input lreg_t lrd,
                               input logic need_wb);
        in_valid      = 1'b1;
        in_lrs1       = lrs1;
        in_lrs2       = lrs2;
        in_lrd        = lrd;
        in_need_to_wb = need_wb;
        in_pc         = next_pc;
        next_pc       = next_pc + 64'd4;
    endtask

    task automatic stop_driving();
        in_valid      = 1'b0;
        in_need_to_wb = 1'b0;
    endtask

    task automatic wait_accept(input int start);
        int waited;
        waited = 0;
        while (accept_count == start && waited < ACCEPT_WAIT) begin
            run_cycle();
            waited++;
        end
        if (accept_count == start) begin
            fail_count++;
            $display("instruction at pc %h not accepted within %0d cycles", in_pc, ACCEPT_WAIT);
        end
    endtask

    task automatic send_instr(input lreg_t lrs1, input lreg_t lrs2, input lreg_t lrd,
                              input logic need_wb);
        int start;
        start = accept_count;
        drive_instr(lrs1, lrs2, lrd, need_wb);
        wait_accept(start);
        stop_driving();
    endtask

    // execution unit result for one ROB entry
    task automatic write_back(input rob_idx_t idx);
        wb_valid      = 1'b1;
        wb_robidx     = idx;
        wb_need_to_wb = m_need[idx];
        wb_prd        = m_prd[idx];
        run_cycle();
        wb_valid      = 1'b0;
        wb_need_to_wb = 1'b0;
    endtask

    task automatic drain_rob();
        int waited;
        waited = 0;
        while (m_head != m_tail && waited < DRAIN_WAIT) begin
            run_cycle();
            waited++;
        end
        if (m_head != m_tail) begin
            fail_count++;
            $display("ROB still holds %0d entries after %0d cycles", m_tail - m_head, DRAIN_WAIT);
        end
        run_cycle();
    endtask

    task automatic complete_all();
        rob_idx_t pend [$];
        for (int k = m_head; k < m_tail; k++) begin
            if (!m_done[k % ROB_DEPTH]) begin
                pend.push_back(rob_idx_t'(k % ROB_DEPTH));
            end
        end
        while (pend.size() > 0) begin
            write_back(pend.pop_front());
        end
        drain_rob();
    endtask

    // each source reads the destination of the instruction before it
    task automatic test_rename_chain();
        lreg_t prev;
        lreg_t dst;
        prev = pick_lreg();
        for (int i = 0; i < 6; i++) begin
            dst = pick_lreg();
            send_instr(prev, pick_lreg(), dst, 1'b1);
            prev = dst;
        end
        complete_all();
    endtask

    task automatic test_rob_wrap();
        for (int i = 0; i < 20; i++) begin
            send_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b0);
            write_back(last_idx);
        end
        drain_rob();
    endtask

    task automatic test_busy_bits();
        lreg_t    src;
        rob_idx_t producer;
        src = pick_lreg();
        send_instr(pick_lreg(), pick_lreg(), src, 1'b1);
        producer = last_idx;
        send_instr(src, pick_lreg(), pick_lreg(), 1'b0);
        // consumer held in the output register while its source completes
        issue_ready = 1'b0;
        run_cycles(2);
        write_back(producer);
        run_cycles(1);
        issue_ready = 1'b1;
        send_instr(pick_lreg(), src, pick_lreg(), 1'b0);
        complete_all();
    endtask

    task automatic test_commit_order();
        rob_idx_t idx [4];
        for (int i = 0; i < 4; i++) begin
            send_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b1);
            idx[i] = last_idx;
        end
        write_back(idx[2]);
        run_cycles(2);
        write_back(idx[0]);
        write_back(idx[3]);
        run_cycles(1);
        write_back(idx[1]);
        drain_rob();
    endtask

    task automatic test_free_list_stall();
        rob_idx_t first;
        rob_idx_t second;
        int       start;
        for (int i = 0; i < int'(NUM_PREG - NUM_LREG); i++) begin
            send_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b1);
            if (i == 0) first = last_idx;
            if (i == 1) second = last_idx;
        end
        drive_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b1);
        start = accept_count;
        run_cycles(4);
        if (accept_count != start) begin
            fail_count++;
            $display("writing instruction accepted with no free physical register");
        end
        write_back(first);
        write_back(second);
        wait_accept(start);
        stop_driving();
        send_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b1);
        complete_all();
    endtask

    task automatic test_backpressure_rob_full();
        int start;
        issue_ready = 1'b0;
        send_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b0);
        drive_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b0);
        start = accept_count;
        run_cycles(3);
        if (accept_count != start) begin
            fail_count++;
            $display("instruction accepted while the issue output was blocked");
        end
        issue_ready = 1'b1;
        wait_accept(start);
        stop_driving();
        for (int i = 0; i < int'(ROB_DEPTH) - 2; i++) begin
            send_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b0);
        end
        // ROB now full
        drive_instr(pick_lreg(), pick_lreg(), pick_lreg(), 1'b0);
        start = accept_count;
        run_cycles(3);
        if (accept_count != start) begin
            fail_count++;
            $display("instruction accepted while the ROB was full");
        end
        write_back(rob_idx_t'(m_head % ROB_DEPTH));
        wait_accept(start);
        stop_driving();
        complete_all();
    endtask

    initial begin
        reset_n       = 1'b0;
        in_valid      = 1'b0;
        in_lrs1       = '0;
        in_lrs2       = '0;
        in_lrd        = '0;
        in_need_to_wb = 1'b0;
        in_pc         = '0;
        issue_ready   = 1'b1;
        wb_valid      = 1'b0;
        wb_robidx     = '0;
        wb_need_to_wb = 1'b0;
        wb_prd        = '0;
        for (int i = 0; i < int'(NUM_LREG); i++) begin
            m_map[i] = preg_t'(i);
        end
        for (int i = NUM_LREG; i < int'(NUM_PREG); i++) begin
            m_free.push_back(preg_t'(i));
        end
        m_busy  = '0;
        m_head  = 0;
        m_tail  = 0;
        e_valid = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        test_rename_chain();
        test_rob_wrap();
        test_busy_bits();
        test_commit_order();
        test_free_list_stall();
        test_backpressure_rob_full();

        $display("errors: %0d value mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
ctrl_types_pkg.sv
rob_pkg.sv
rename_table.sv
free_list.sv
busy_table.sv
reorder_buffer.sv
rename_stage.sv
ctrl_block.sv
tb_ctrl_block.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal
TOP       := tb_ctrl_block
FILELIST  := project.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
